// ==== common/uart_pkg.sv ====
// ==========================================================
// shared widths and limits of the UART line format
// imported by the control block, both datapath blocks,
// the top level and the testbench
// ==========================================================

`default_nettype none

package uart_pkg;

    // baud divider width
    // one bit lasts baud_div + 1 clock cycles
    localparam int BAUD_W = 16;

    // widest frame payload, also the stream word width
    localparam int DATA_W = 8;

    // width of the data length setting
    localparam int LEN_W = 4;

    // legal data lengths
    // anything outside is clamped when captured by uart_ctrl
    localparam int LEN_MIN = 5;
    localparam int LEN_MAX = 8;

endpackage

`default_nettype wire

// ==== hw/uart_ctrl.sv ====
// ==========================================================
// pause handshake and line settings for the UART peripheral
// pause_ack is given once both datapath blocks are idle;
// new settings are captured only while paused, so a frame
// never sees its format change
// ==========================================================

`default_nettype none

module uart_ctrl import uart_pkg::*; (
    input  logic              clk,
    input  logic              rst,

    input  logic              pause_req,
    output logic              pause_ack,
    input  logic              rx_busy,
    input  logic              tx_busy,
    output logic              halt,
    output logic              freeze,

    input  logic [LEN_W-1:0]  data_length,
    input  logic              parity_enable,
    input  logic              parity_odd,
    input  logic              two_stop,
    input  logic [BAUD_W-1:0] baud_div,

    output logic [LEN_W-1:0]  act_length,
    output logic              act_parity_en,
    output logic              act_parity_odd,
    output logic              act_two_stop,
    output logic [BAUD_W-1:0] act_baud_div
);

    logic [LEN_W-1:0] len_clamped;

    // no new frames once a pause is requested
    assign halt   = pause_req;
    // datapath holds everything while acknowledged
    assign freeze = pause_ack;

    always_comb begin
        if (data_length < LEN_W'(LEN_MIN)) begin
            len_clamped = LEN_W'(LEN_MIN);
        end else if (data_length > LEN_W'(LEN_MAX)) begin
            len_clamped = LEN_W'(LEN_MAX);
        end else begin
            len_clamped = data_length;
        end
    end

    // ack rises when both sides are idle, falls right after req drops
    always_ff @(posedge clk) begin
        if (rst) begin
            pause_ack <= 1'b0;
        end else begin
            pause_ack <= pause_req && (pause_ack || (!rx_busy && !tx_busy));
        end
    end

    // active configuration, 8N1 with divider 15 after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            act_length     <= LEN_W'(LEN_MAX);
            act_parity_en  <= 1'b0;
            act_parity_odd <= 1'b0;
            act_two_stop   <= 1'b0;
            act_baud_div   <= BAUD_W'(15);
        end else if (pause_req && pause_ack) begin
            act_length     <= len_clamped;
            act_parity_en  <= parity_enable;
            act_parity_odd <= parity_odd;
            act_two_stop   <= two_stop;
            act_baud_div   <= baud_div;
        end
    end

    // a dropped request always takes the ack down on the next cycle
    a_ack_follows_req: assert property (
        @(posedge clk) disable iff (rst)
        !pause_req |=> !pause_ack
    );

endmodule

`default_nettype wire

// ==== uart_rx/uart_rx.sv ====
// ==========================================================
// UART receiver
// synchronizes rx, samples each bit at its middle, checks
// start, parity and stop bits, and offers good words on a
// valid/ready stream; bad frames pulse rx_error
// ==========================================================

`default_nettype none

module uart_rx import uart_pkg::*; (
    input  logic              clk,
    input  logic              rst,

    input  logic              halt,
    input  logic              freeze,
    output logic              rx_busy,

    input  logic              rx,

    input  logic [LEN_W-1:0]  act_length,
    input  logic              act_parity_en,
    input  logic              act_parity_odd,
    input  logic              act_two_stop,
    input  logic [BAUD_W-1:0] act_baud_div,

    output logic [DATA_W-1:0] rx_data,
    output logic              rx_valid,
    input  logic              rx_ready,
    output logic              rx_error
);

    logic              rx_meta;
    logic              rx_sync;
    logic              rx_last;
    logic              start_edge;

    logic              in_frame;
    logic [BAUD_W-1:0] cnt;
    logic [3:0]        bit_cnt;
    logic              parity;

    logic [3:0]        stop_first;
    logic [3:0]        stop_last;

    // frame positions, 0 is the start bit
    assign stop_first = act_length + 4'(act_parity_en) + 4'd1;
    assign stop_last  = stop_first + 4'(act_two_stop);

    assign start_edge = rx_last && !rx_sync;
    assign rx_busy    = in_frame || rx_valid;

    // two flop synchronizer plus edge history, idles high
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_last <= 1'b1;
        end else if (!freeze) begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_last <= rx_sync;
        end
    end

    // control state
    always_ff @(posedge clk) begin
        if (rst) begin
            in_frame <= 1'b0;
            rx_valid <= 1'b0;
            rx_error <= 1'b0;
            cnt      <= '0;
            bit_cnt  <= '0;
        end else if (!freeze) begin
            rx_error <= 1'b0;
            if (rx_valid) begin
                // word waits here until it is taken
                if (rx_ready) begin
                    rx_valid <= 1'b0;
                end
            end else if (!in_frame) begin
                if (!halt && start_edge) begin
                    in_frame <= 1'b1;
                    cnt      <= act_baud_div >> 1;
                    bit_cnt  <= '0;
                end
            end else if (cnt != '0) begin
                cnt <= cnt - 1'b1;
            end else begin
                // mid-bit sample
                cnt     <= act_baud_div;
                bit_cnt <= bit_cnt + 4'd1;
                if (bit_cnt == 4'd0) begin
                    if (rx_sync) begin
                        in_frame <= 1'b0;
                        rx_error <= 1'b1;
                    end
                end else if (bit_cnt > act_length && bit_cnt < stop_first) begin
                    if (parity ^ rx_sync) begin
                        in_frame <= 1'b0;
                        rx_error <= 1'b1;
                    end
                end else if (bit_cnt >= stop_first) begin
                    if (!rx_sync) begin
                        in_frame <= 1'b0;
                        rx_error <= 1'b1;
                    end else if (bit_cnt == stop_last) begin
                        in_frame <= 1'b0;
                        rx_valid <= 1'b1;
                    end
                end
            end
        end
    end

    // payload, cleared at the start edge so high bits read zero
    always_ff @(posedge clk) begin
        if (!freeze && !rx_valid) begin
            if (!in_frame && !halt && start_edge) begin
                rx_data <= '0;
                parity  <= act_parity_odd;
            end else if (in_frame && cnt == '0 && bit_cnt != 4'd0
                         && bit_cnt <= act_length) begin
                // data bits LSB first
                rx_data[3'(bit_cnt - 4'd1)] <= rx_sync;
                parity                      <= parity ^ rx_sync;
            end
        end
    end

    a_rx_hold: assert property (
        @(posedge clk) disable iff (rst)
        rx_valid && !rx_ready && !freeze |=> rx_valid && $stable(rx_data)
    );

endmodule

`default_nettype wire

// ==== uart_tx/uart_tx.sv ====
// ==========================================================
// UART transmitter
// takes one word from the valid/ready stream when idle and
// sends start bit, data LSB first, optional parity and one
// or two stop bits, each held baud_div + 1 cycles
// ==========================================================

`default_nettype none

module uart_tx import uart_pkg::*; (
    input  logic              clk,
    input  logic              rst,

    input  logic              halt,
    input  logic              freeze,
    output logic              tx_busy,

    input  logic [DATA_W-1:0] tx_data,
    input  logic              tx_valid,
    output logic              tx_ready,

    input  logic [LEN_W-1:0]  act_length,
    input  logic              act_parity_en,
    input  logic              act_parity_odd,
    input  logic              act_two_stop,
    input  logic [BAUD_W-1:0] act_baud_div,

    output logic              tx
);

    logic              sending;
    logic              accept;
    logic [BAUD_W-1:0] cnt;
    logic [3:0]        bit_cnt;
    logic [3:0]        last_pos;
    logic [DATA_W-1:0] len_mask;
    logic [DATA_W-1:0] shreg;
    logic              par_bit;

    always_comb begin
        for (int i = 0; i < DATA_W; i++) begin
            len_mask[i] = (i < int'(act_length));
        end
    end

    // position of the final stop bit, 0 is the start bit
    assign last_pos = act_length + 4'(act_parity_en) + 4'(act_two_stop) + 4'd1;

    assign tx_busy  = sending;
    assign tx_ready = accept && !halt && !freeze;

    always_ff @(posedge clk) begin
        if (rst) begin
            sending <= 1'b0;
            accept  <= 1'b0;
            cnt     <= '0;
            bit_cnt <= '0;
            tx      <= 1'b1;
        end else if (!freeze) begin
            if (!sending) begin
                // ready from the cycle after reset
                accept <= 1'b1;
                if (tx_valid && tx_ready) begin
                    sending <= 1'b1;
                    accept  <= 1'b0;
                    cnt     <= act_baud_div;
                    bit_cnt <= '0;
                    tx      <= 1'b0;
                end
            end else if (cnt != '0) begin
                cnt <= cnt - 1'b1;
            end else if (bit_cnt == last_pos) begin
                // last stop bit done
                sending <= 1'b0;
                accept  <= 1'b1;
            end else begin
                cnt     <= act_baud_div;
                bit_cnt <= bit_cnt + 4'd1;
                if (bit_cnt < act_length) begin
                    tx <= shreg[0];
                end else if (bit_cnt == act_length && act_parity_en) begin
                    tx <= par_bit;
                end else begin
                    tx <= 1'b1;
                end
            end
        end
    end

    // payload, bits above act_length masked off at load
    always_ff @(posedge clk) begin
        if (!freeze) begin
            if (!sending && tx_valid && tx_ready) begin
                shreg   <= tx_data & len_mask;
                par_bit <= act_parity_odd ^ (^(tx_data & len_mask));
            end else if (sending && cnt == '0 && bit_cnt < act_length) begin
                shreg <= shreg >> 1;
            end
        end
    end

    // line idles high between frames
    a_tx_idle_high: assert property (
        @(posedge clk) disable iff (rst)
        !tx_busy |-> tx
    );

endmodule

`default_nettype wire

// ==== hw/uart_periph.sv ====
// ==========================================================
// UART peripheral top level
// control block feeds the active line settings and the
// pause signals to the receiver and the transmitter
// ==========================================================

`default_nettype none

module uart_periph import uart_pkg::*; (
    input  logic              clk,
    input  logic              rst,

    input  logic              pause_req,
    output logic              pause_ack,

    input  logic [LEN_W-1:0]  data_length,
    input  logic              parity_enable,
    input  logic              parity_odd,
    input  logic              two_stop,
    input  logic [BAUD_W-1:0] baud_div,

    input  logic              rx,
    output logic [DATA_W-1:0] rx_data,
    output logic              rx_valid,
    input  logic              rx_ready,
    output logic              rx_error,

    input  logic [DATA_W-1:0] tx_data,
    input  logic              tx_valid,
    output logic              tx_ready,
    output logic              tx
);

    logic              halt;
    logic              freeze;
    logic              rx_busy;
    logic              tx_busy;

    // settings in force for both directions
    logic [LEN_W-1:0]  act_length;
    logic              act_parity_en;
    logic              act_parity_odd;
    logic              act_two_stop;
    logic [BAUD_W-1:0] act_baud_div;

    uart_ctrl u_ctrl (
        .clk            (clk),
        .rst            (rst),
        .pause_req      (pause_req),
        .pause_ack      (pause_ack),
        .rx_busy        (rx_busy),
        .tx_busy        (tx_busy),
        .halt           (halt),
        .freeze         (freeze),
        .data_length    (data_length),
        .parity_enable  (parity_enable),
        .parity_odd     (parity_odd),
        .two_stop       (two_stop),
        .baud_div       (baud_div),
        .act_length     (act_length),
        .act_parity_en  (act_parity_en),
        .act_parity_odd (act_parity_odd),
        .act_two_stop   (act_two_stop),
        .act_baud_div   (act_baud_div)
    );

    uart_rx u_rx (
        .clk            (clk),
        .rst            (rst),
        .halt           (halt),
        .freeze         (freeze),
        .rx_busy        (rx_busy),
        .rx             (rx),
        .act_length     (act_length),
        .act_parity_en  (act_parity_en),
        .act_parity_odd (act_parity_odd),
        .act_two_stop   (act_two_stop),
        .act_baud_div   (act_baud_div),
        .rx_data        (rx_data),
        .rx_valid       (rx_valid),
        .rx_ready       (rx_ready),
        .rx_error       (rx_error)
    );

    uart_tx u_tx (
        .clk            (clk),
        .rst            (rst),
        .halt           (halt),
        .freeze         (freeze),
        .tx_busy        (tx_busy),
        .tx_data        (tx_data),
        .tx_valid       (tx_valid),
        .tx_ready       (tx_ready),
        .act_length     (act_length),
        .act_parity_en  (act_parity_en),
        .act_parity_odd (act_parity_odd),
        .act_two_stop   (act_two_stop),
        .act_baud_div   (act_baud_div),
        .tx             (tx)
    );

endmodule

`default_nettype wire

// ==== dv/uart_periph_tb.sv ====
// ============================================================
// directed testbench for the UART peripheral
// a line model drives rx frames and decodes tx frames from a
// model of the active settings, which changes only by a pause
// ============================================================

`default_nettype none

module uart_periph_tb import uart_pkg::*; ();

    localparam int WAIT_MAX = 4000;

    logic              clk = 1'b0;
    logic              rst;
    logic              pause_req;
    logic              pause_ack;
    logic [LEN_W-1:0]  data_length;
    logic              parity_enable;
    logic              parity_odd;
    logic              two_stop;
    logic [BAUD_W-1:0] baud_div;
    logic              rx;
    logic [DATA_W-1:0] rx_data;
    logic              rx_valid;
    logic              rx_ready;
    logic              rx_error;
    logic [DATA_W-1:0] tx_data;
    logic              tx_valid;
    logic              tx_ready;
    logic              tx;

    // model of the settings in force inside the DUT
    logic [LEN_W-1:0]  m_len;
    logic              m_pen;
    logic              m_podd;
    logic              m_two;
    logic [BAUD_W-1:0] m_div;
    int                err_cnt;
    int                valid_cnt;

    uart_periph uut (.*);

    always #2 clk = ~clk;

    function automatic int bit_cycles();
        return int'(m_div) + 1;
    endfunction

    function automatic int frame_len();
        return int'(m_len) + int'(m_pen) + int'(m_two) + 2;
    endfunction

    // wraps to all ones at full length
    function automatic logic [DATA_W-1:0] len_mask();
        return (DATA_W'(1) << m_len) - DATA_W'(1);
    endfunction

    // ones in data and parity bit add up to an odd count only for odd parity
    function automatic logic parity_bit(logic [DATA_W-1:0] w);
        int ones;
        ones = 0;
        for (int i = 0; i < int'(m_len); i++) begin
            ones += int'(w[i]);
        end
        return ((ones % 2) == 1) != m_podd;
    endfunction

    // expected line level at frame position pos, 0 is the start bit
    function automatic logic frame_bit(logic [DATA_W-1:0] w, int pos);
        if (pos == 0) return 1'b0;
        if (pos <= int'(m_len)) return w[pos-1];
        if (m_pen && pos == int'(m_len) + 1) return parity_bit(w);
        return 1'b1;
    endfunction

    task automatic stop_run();
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_word(string name, logic [DATA_W-1:0] got, logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_bit(int pos, logic got, logic exp);
        if (got !== exp) begin
            $display("Error: tx bit %0d got 0x%h expected 0x%h", pos, got, exp);
            stop_run();
        end
    endtask

    task automatic to_drive();
        @(posedge clk);
        #1;
    endtask

    // one clock, counting receiver flags at the falling edge
    task automatic tick();
        @(negedge clk);
        err_cnt   += int'(rx_error);
        valid_cnt += int'(rx_valid);
        to_drive();
    endtask

    // polls at falling edges, returns on the edge where the condition holds
    task automatic wait_for(string what);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < WAIT_MAX && !hit; i++) begin
            @(negedge clk);
            if (what == "rx_valid") hit = rx_valid;
            else if (what == "tx_ready") hit = tx_ready;
            else if (what == "tx start bit") hit = !tx;
            else if (what == "pause_ack high") hit = pause_ack;
            else hit = !pause_ack;
        end
        if (!hit) begin
            $display("timeout while waiting for %s", what);
            stop_run();
        end
    endtask

    task automatic watch_cycles(int n);
        repeat (n) begin
            @(negedge clk);
            check_flag("pause_ack", pause_ack, 1'b0);
        end
    endtask

    task automatic apply_settings(int len, logic pen, logic podd, logic two, int div);
        pause_req = 1'b1;
        wait_for("pause_ack high");
        to_drive();
        data_length   = LEN_W'(len);
        parity_enable = pen;
        parity_odd    = podd;
        two_stop      = two;
        baud_div      = BAUD_W'(div);
        repeat (3) tick();
        pause_req = 1'b0;
        wait_for("pause_ack low");
        to_drive();
        m_len  = LEN_W'(len);
        m_pen  = pen;
        m_podd = podd;
        m_two  = two;
        m_div  = BAUD_W'(div);
    endtask

    // line model, receive side of the DUT
    task automatic drive_rx(logic [DATA_W-1:0] w, bit bad_par, bit bad_stop);
        logic b;
        for (int pos = 0; pos < frame_len(); pos++) begin
            b = frame_bit(w, pos);
            if (bad_par && pos == int'(m_len) + 1) b = !b;
            if (bad_stop && pos == frame_len() - 1) b = 1'b0;
            rx = b;
            repeat (bit_cycles()) tick();
        end
        rx = 1'b1;
        repeat (2) tick();
    endtask

    // line model, transmit side, samples each bit at its middle
    task automatic capture_tx(logic [DATA_W-1:0] w, bit check_ready);
        int half;
        half = bit_cycles() / 2;
        wait_for("tx start bit");
        for (int pos = 0; pos < frame_len(); pos++) begin
            watch_cycles(pos == 0 ? half : bit_cycles());
            check_bit(pos, tx, frame_bit(w, pos));
        end
        if (check_ready) begin
            watch_cycles(bit_cycles() - half - 1);
            check_flag("tx_ready", tx_ready, 1'b0);
            watch_cycles(1);
            check_flag("tx_ready", tx_ready, 1'b1);
        end else begin
            // ack stays low up to the end of the last stop bit
            watch_cycles(bit_cycles() - half);
        end
        to_drive();
    endtask

    task automatic accept_tx();
        wait_for("tx_ready");
        to_drive();
        tx_valid = 1'b0;
    endtask

    task automatic send_tx(logic [DATA_W-1:0] w);
        tx_data  = w;
        tx_valid = 1'b1;
        accept_tx();
        capture_tx(w, 1'b1);
    endtask

    task automatic recv_check(logic [DATA_W-1:0] w, int hold);
        err_cnt = 0;
        drive_rx(w, 1'b0, 1'b0);
        wait_for("rx_valid");
        repeat (hold) begin
            @(negedge clk);
            check_flag("rx_valid", rx_valid, 1'b1);
            check_word("rx_data", rx_data, w & len_mask());
        end
        to_drive();
        rx_ready = 1'b1;
        @(negedge clk);
        check_word("rx_data", rx_data, w & len_mask());
        to_drive();
        rx_ready = 1'b0;
        @(negedge clk);
        check_flag("rx_valid", rx_valid, 1'b0);
        check_flag("rx_error", err_cnt != 0, 1'b0);
        to_drive();
    endtask

    task automatic both_ways(logic [DATA_W-1:0] w);
        send_tx(w);
        recv_check(w, 3);
    endtask

    task automatic test_tx_format();
        repeat (4) send_tx(DATA_W'($urandom));
    endtask

    task automatic test_rx();
        recv_check(DATA_W'($urandom), 0);
        recv_check(DATA_W'($urandom), 12);
    endtask

    task automatic test_formats();
        apply_settings(5, 1'b1, 1'b0, 1'b0, 15);
        both_ways(DATA_W'($urandom));
        apply_settings(7, 1'b1, 1'b1, 1'b0, 15);
        both_ways(8'hff);
        apply_settings(8, 1'b0, 1'b0, 1'b1, 7);
        both_ways(DATA_W'($urandom));
        apply_settings(7, 1'b1, 1'b0, 1'b1, 7);
        both_ways(DATA_W'($urandom));
        // inputs moved outside a pause must not reach the datapath
        data_length   = LEN_W'(5);
        parity_enable = 1'b0;
        baud_div      = BAUD_W'(3);
        both_ways(DATA_W'($urandom));
    endtask

    task automatic test_error_frames();
        apply_settings(8, 1'b1, 1'b1, 1'b0, 7);
        for (int k = 0; k < 2; k++) begin
            err_cnt   = 0;
            valid_cnt = 0;
            drive_rx(DATA_W'($urandom), k == 0, k == 1);
            repeat (4) tick();
            check_flag("rx_error pulse", err_cnt == 1, 1'b1);
            check_flag("rx_valid", valid_cnt != 0, 1'b0);
        end
        recv_check(DATA_W'($urandom), 2);
    endtask

    task automatic test_pause();
        logic [DATA_W-1:0] w;
        w        = DATA_W'($urandom);
        tx_data  = w;
        tx_valid = 1'b1;
        accept_tx();
        pause_req = 1'b1;
        // ack must wait for the frame in flight
        capture_tx(w, 1'b0);
        wait_for("pause_ack high");
        for (int k = 0; k < 8; k++) begin
            if (k == 4) begin
                to_drive();
                w        = DATA_W'($urandom);
                tx_data  = w;
                tx_valid = 1'b1;
            end
            @(negedge clk);
            check_flag("tx_ready", tx_ready, 1'b0);
            check_flag("tx", tx, 1'b1);
        end
        to_drive();
        pause_req = 1'b0;
        accept_tx();
        capture_tx(w, 1'b1);
    endtask

    initial begin
        void'($urandom(11324));
        rst           = 1'b1;
        pause_req     = 1'b0;
        data_length   = LEN_W'(LEN_MAX);
        parity_enable = 1'b0;
        parity_odd    = 1'b0;
        two_stop      = 1'b0;
        baud_div      = BAUD_W'(15);
        rx            = 1'b1;
        rx_ready      = 1'b0;
        tx_data       = '0;
        tx_valid      = 1'b0;
        m_len         = LEN_W'(LEN_MAX);
        m_pen         = 1'b0;
        m_podd        = 1'b0;
        m_two         = 1'b0;
        m_div         = BAUD_W'(15);
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        test_tx_format();
        test_rx();
        test_formats();
        test_error_frames();
        test_pause();
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== uart_periph.f ====
common/uart_pkg.sv
hw/uart_ctrl.sv
uart_rx/uart_rx.sv
uart_tx/uart_tx.sv
hw/uart_periph.sv
dv/uart_periph_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the UART peripheral testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module uart_periph_tb -f uart_periph.f -o uart_periph_sim

out=$(./obj_dir/uart_periph_sim) || true
echo "$out"

if echo "$out" | grep -qx "NO ERRORS"; then
    exit 0
fi
echo "simulation failed"
exit 1
